// ==== design/boot_addr_mapper.sv ====
// maps a download address to an external memory address, bank and write enable
`include "cpc_cfg.svh"

module boot_addr_mapper (
	input  cpc_pkg::byte_t             ioctl_index,
	input  logic                       ioctl_download,
	input  logic                       ioctl_wr,
	input  logic [`IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  cpc_pkg::page_t             page,
	input  logic                       model,
	output logic                       boot_wr,
	output cpc_pkg::boot_addr_t        boot_addr,
	output cpc_pkg::bank_t             boot_bank
);

	logic rom_download;
	logic ext_download;
	logic [`IOCTL_ADDR_W-15:0] segment;   // 16 KB segment of the image

	assign rom_download = ioctl_download && (ioctl_index == `IDX_ROM);
	assign ext_download = ioctl_download && (ioctl_index == `IDX_EXT);
	assign segment      = ioctl_addr[`IOCTL_ADDR_W-1:14];

	// lower 4 MB holds OS, RAM and MF2 ROM; upper 4 MB holds up to 256 high ROMs
	always_comb begin
		boot_wr                         = (rom_download | ext_download) & ioctl_wr;
		boot_addr[13:0]                 = ioctl_addr[13:0];
		boot_addr[`BOOT_ADDR_W-1:14]    = '1;
		boot_bank                       = '0;

		if (ext_download) begin
			boot_addr[`BOOT_ADDR_W-1]   = page[8];
			boot_addr[21:14]            = page[7:0] + ioctl_addr[21:14];
			boot_bank                   = {1'b0, model};
		end else begin
			case (segment)
				0, 4:    boot_addr[`BOOT_ADDR_W-1:14] = `PAGE_OS;
				1, 5:    boot_addr[`BOOT_ADDR_W-1:14] = `PAGE_BASIC;
				2, 6:    boot_addr[`BOOT_ADDR_W-1:14] = `PAGE_AMSDOS;
				3, 7:    boot_addr[`BOOT_ADDR_W-1:14] = `PAGE_MF2;
				default: boot_wr = 1'b0;   // past the end of the firmware
			endcase
			// second set of four segments is the 664 firmware
			if (segment >= 4 && segment <= 7)
				boot_bank = 'd1;
		end
	end

	// a write from the host only ever lands inside a download
	boot_wr_in_download: assert property (@(posedge ioctl_wr) ioctl_download);

endmodule

// ==== design/cpc_cfg.svh ====
// shared widths, download indices, fixed pages and Multiface addresses; include where needed
`ifndef CPC_CFG_SVH
`define CPC_CFG_SVH

////////////////////////////////////////
// widths

`define BOOT_ADDR_W    23     // 8 MB of external memory, 16 KB pages
`define BANK_W         2
`define IOCTL_ADDR_W   25     // download address from the host
`define ROM_MAP_W      256    // one bit per high ROM page
`define MF2_RAM_AW     13     // 8 KB Multiface RAM

////////////////////////////////////////
// download indices

`define IDX_ROM        8'd0   // firmware image
`define IDX_EXT        8'd3   // expansion ROM, page from file extension

////////////////////////////////////////
// fixed pages, bit 8 picks the high ROM half

`define PAGE_OS        9'h000
`define PAGE_BASIC     9'h100
`define PAGE_AMSDOS    9'h107
`define PAGE_MF2       9'h0FF
`define PAGE_BAD_EXT   9'h1EE // unused page, catches a malformed extension
`define PAGE_COMBO_END 9'h1FF

// Multiface addresses
`define MF2_NMI_VEC    16'h0066
`define MF2_HIDE_ADDR  16'h0065
`define MF2_PORT_HI    14'b11111110111010 // FEE8 and FEEA

`endif

// ==== design/cpc_glue_top.sv ====
// boot loader and Multiface Two glue; instance this between the host link, memory and CPU
`include "cpc_cfg.svh"

module cpc_glue_top (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       ioctl_download,
	input  cpc_pkg::byte_t             ioctl_index,
	input  logic                       ioctl_wr,
	input  logic [`IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  cpc_pkg::byte_t             ioctl_dout,
	input  logic [23:0]                ioctl_file_ext,
	input  logic                       model,
	input  cpc_pkg::cpu_addr_t         cpu_addr,
	input  cpc_pkg::byte_t             cpu_dout,
	input  logic                       cpu_m1,
	input  logic                       cpu_iorq,
	input  logic                       cpu_rd,
	input  logic                       cpu_wr,
	input  logic                       mem_rd,
	input  logic                       mem_wr,
	input  logic                       key_nmi,
	input  cpc_pkg::mf2_mode_t         mf2_mode,
	output logic                       boot_wr,
	output cpc_pkg::boot_addr_t        boot_addr,
	output cpc_pkg::bank_t             boot_bank,
	output cpc_pkg::byte_t             boot_data,
	output logic [`ROM_MAP_W-1:0]      rom_map,
	output logic                       mf2_nmi,
	output logic                       mf2_rom_en,
	output logic                       mf2_ram_en,
	output cpc_pkg::byte_t             mf2_dout
);
	import cpc_pkg::*;

	page_t page;
	logic  port_wr;
	logic  mf2_en;

	cpu_bus_if u_bus ();

	assign u_bus.addr   = cpu_addr;
	assign u_bus.dout   = cpu_dout;
	assign u_bus.m1     = cpu_m1;
	assign u_bus.io_wr  = cpu_iorq & cpu_wr & ~cpu_rd;   // io write cycle only
	assign u_bus.mem_rd = mem_rd;
	assign u_bus.mem_wr = mem_wr;

	assign boot_data = ioctl_dout;   // bytes go to memory as they come

	boot_addr_mapper u_mapper (
		.ioctl_index(ioctl_index), .ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .page(page), .model(model),
		.boot_wr(boot_wr), .boot_addr(boot_addr), .boot_bank(boot_bank)
	);

	rom_page_tracker u_tracker (
		.clk_sys(clk_sys), .reset(reset), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr), .ioctl_file_ext(ioctl_file_ext),
		.boot_addr(boot_addr), .boot_wr_region(boot_wr), .page(page), .rom_map(rom_map)
	);

	mf2_control u_ctrl (
		.clk_sys(clk_sys), .reset(reset), .bus(u_bus.ctrl), .key_nmi(key_nmi),
		.mf2_mode(mf2_mode), .mf2_nmi(mf2_nmi), .mf2_en(mf2_en), .port_wr(port_wr),
		.mf2_rom_en(mf2_rom_en), .mf2_ram_en(mf2_ram_en)
	);

	mf2_shadow_ram u_shadow (
		.clk_sys(clk_sys), .reset(reset), .bus(u_bus.ram), .port_wr(port_wr),
		.mf2_en(mf2_en), .mf2_ram_en(mf2_ram_en), .mf2_dout(mf2_dout)
	);

endmodule

// ==== design/cpc_pkg.sv ====
// types shared by the loader and the Multiface blocks; import where a type is needed
`include "cpc_cfg.svh"

package cpc_pkg;

	// external memory address, 16 KB pages above bit 14
	typedef logic [`BOOT_ADDR_W-1:0] boot_addr_t;

	// page number, bit 8 set for the high ROM half
	typedef logic [8:0] page_t;

	typedef logic [`BANK_W-1:0] bank_t;     // memory bank

	typedef logic [15:0] cpu_addr_t;

	typedef logic [7:0] byte_t;

	typedef logic [`MF2_RAM_AW-1:0] mf2_addr_t;

	// bit 1 switches the Multiface off, any nonzero value starts it hidden
	typedef enum logic [1:0] {
		MF2_ENABLED  = 2'b00,
		MF2_HIDDEN   = 2'b01,
		MF2_DISABLED = 2'b10
	} mf2_mode_t;

endpackage

// ==== design/cpu_bus_if.sv ====
// CPU bus as seen by the Multiface blocks; driven from the top level CPU ports
interface cpu_bus_if;
	import cpc_pkg::*;

	cpu_addr_t addr;
	byte_t     dout;    // data from the CPU
	logic      m1;      // opcode fetch
	logic      io_wr;   // wr and iorq together
	logic      mem_rd;
	logic      mem_wr;

	// paging and port logic
	modport ctrl (
		input addr,
		input m1,
		input io_wr
	);

	// shadow store and RAM access
	modport ram (
		input addr,
		input dout,
		input mem_rd,
		input mem_wr
	);

endinterface

// ==== design/mf2_control.sv ====
// Multiface Two NMI, paging and hide state, with the FEE8/FEEA port decode
`include "cpc_cfg.svh"

module mf2_control (
	input  logic                clk_sys,
	input  logic                reset,
	cpu_bus_if.ctrl             bus,
	input  logic                key_nmi,
	input  cpc_pkg::mf2_mode_t  mf2_mode,
	output logic                mf2_nmi,
	output logic                mf2_en,
	output logic                port_wr,
	output logic                mf2_rom_en,
	output logic                mf2_ram_en
);
	import cpc_pkg::*;

	logic key_d;
	logic m1_d;
	logic io_wr_d;
	logic mf2_hidden;     // ignores the enable port until the next NMI
	logic key_rise;
	logic m1_rise;
	logic io_rise;
	logic port_hit;

	assign key_rise = key_nmi & ~key_d;
	assign m1_rise  = bus.m1 & ~m1_d;
	assign io_rise  = bus.io_wr & ~io_wr_d;
	assign port_hit = (bus.addr[15:2] == `MF2_PORT_HI);

	// every other io write goes to the shadow store
	assign port_wr = io_rise & ~port_hit;

	assign mf2_rom_en = mf2_en & (bus.addr[15:13] == 3'b000);   // 0000-1FFF
	assign mf2_ram_en = mf2_en & (bus.addr[15:13] == 3'b001);   // 2000-3FFF

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_d      <= 1'b0;
			m1_d       <= 1'b0;
			io_wr_d    <= 1'b0;
			mf2_nmi    <= 1'b0;
			mf2_en     <= 1'b0;
			mf2_hidden <= (mf2_mode != MF2_ENABLED);
		end else begin
			key_d   <= key_nmi;
			m1_d    <= bus.m1;
			io_wr_d <= bus.io_wr;

			if (key_rise & ~mf2_en & ~mf2_mode[1])
				mf2_nmi <= 1'b1;
			if (mf2_nmi & m1_rise & (bus.addr == `MF2_NMI_VEC)) begin
				mf2_en     <= 1'b1;    // page in on the NMI vector fetch
				mf2_hidden <= 1'b0;
				mf2_nmi    <= 1'b0;
			end
			if (mf2_en & m1_rise & (bus.addr == `MF2_HIDE_ADDR))
				mf2_hidden <= 1'b1;
			// FEE8 pages in, FEEA pages out; hidden or off keeps it out
			if (io_rise & port_hit)
				mf2_en <= ~bus.addr[1] & ~mf2_hidden & ~mf2_mode[1];
		end
	end

	nmi_off_when_disabled: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(mf2_nmi) |-> !$past(mf2_mode[1]));

endmodule

// ==== design/mf2_shadow_ram.sv ====
// Multiface RAM with the shadow store of gate array, CRTC, 8255 and upper ROM writes
`include "cpc_cfg.svh"

module mf2_shadow_ram (
	input  logic            clk_sys,
	input  logic            reset,
	cpu_bus_if.ram          bus,
	input  logic            port_wr,
	input  logic            mf2_en,
	input  logic            mf2_ram_en,
	output cpc_pkg::byte_t  mf2_dout
);
	import cpc_pkg::*;

	byte_t      mem [0:(1 << `MF2_RAM_AW) - 1];
	mf2_addr_t  store_addr;    // zero when the port is not shadowed
	mf2_addr_t  ram_a;
	byte_t      ram_in;
	byte_t      ram_out;
	logic       ram_we;
	logic [4:0] pen_index;
	logic [3:0] crtc_reg;
	logic       store_hit;
	logic       direct_wr;

	////////////////////////////////////////
	// store address decode

	always_comb begin
		store_addr = '0;
		case (bus.addr[15:8])
			8'h7F: begin // gate array, function in the top two data bits
				case (bus.dout[7:6])
					2'b00:   store_addr = 13'h1FCF;   // pen index
					2'b01:   store_addr = pen_index[4] ? 13'h1FDF : {9'h1F9, pen_index[3:0]};
					2'b10:   store_addr = 13'h1FEF;   // screen mode
					default: store_addr = 13'h1FFF;   // banking
				endcase
			end
			8'hBC:   store_addr = 13'h1CFF;           // CRTC register select
			8'hBD:   store_addr = {9'h1DB, crtc_reg}; // CRTC register value
			8'hF7:   store_addr = 13'h17FF;           // 8255 control
			8'hDF:   store_addr = 13'h1AAC;           // upper ROM select
			default: store_addr = '0;
		endcase
	end

	assign store_hit = port_wr & |store_addr;
	assign direct_wr = bus.mem_wr & mf2_ram_en;

	////////////////////////////////////////
	// RAM request, one cycle behind the bus

	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= store_hit | direct_wr;
	end

	always_ff @(posedge clk_sys) begin
		if (store_hit) begin
			if (bus.addr[15:8] == 8'h7F && bus.dout[7:6] == 2'b00)
				pen_index <= bus.dout[4:0];
			if (bus.addr[15:8] == 8'hBC)
				crtc_reg <= bus.dout[3:0];
			ram_a  <= store_addr;
			ram_in <= bus.dout;
		end else if (direct_wr) begin
			ram_a  <= bus.addr[`MF2_RAM_AW-1:0];
			ram_in <= bus.dout;
		end else if (mf2_en) begin
			ram_a <= bus.addr[`MF2_RAM_AW-1:0];   // read address, held while paged out
		end
	end

	// write-through, so a store shows on the next read of the same address
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_a] <= ram_in;
			ram_out    <= ram_in;
		end else begin
			ram_out <= mem[ram_a];
		end
	end

	assign mf2_dout = (mf2_ram_en & bus.mem_rd) ? ram_out : 8'hFF;   // FF lets others drive

endmodule

// ==== design/rom_page_tracker.sv ====
// picks the expansion ROM page from the file extension and records written high ROM pages
`include "cpc_cfg.svh"

module rom_page_tracker (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_download,
	input  cpc_pkg::byte_t          ioctl_index,
	input  logic                    ioctl_wr,
	input  logic [23:0]             ioctl_file_ext,
	input  cpc_pkg::boot_addr_t     boot_addr,
	input  logic                    boot_wr_region,
	output cpc_pkg::page_t          page,
	output logic [`ROM_MAP_W-1:0]   rom_map
);
	import cpc_pkg::*;

	logic       download_d;
	logic       wr_d;          // previous cycle carried a mapped write
	logic       combo;
	logic       ext_start;
	logic       wr_fall;
	logic [4:0] hi_digit;      // valid flag and nibble
	logic [4:0] lo_digit;
	page_t      ext_page;
	logic       ext_combo;

	// one extension character as a hex nibble, bit 4 marks a valid digit
	function automatic logic [4:0] hex_digit(input byte_t c);
		if (c >= "0" && c <= "9")
			return {1'b1, c[3:0]};
		if (c >= "A" && c <= "F")
			return {1'b1, c[3:0] + 4'd9};
		return 5'd0;
	endfunction

	assign ext_start = ~download_d & ioctl_download & (ioctl_index == `IDX_EXT);
	assign wr_fall   = wr_d & ~ioctl_wr;
	assign hi_digit  = hex_digit(ioctl_file_ext[15:8]);
	assign lo_digit  = hex_digit(ioctl_file_ext[7:0]);

	always_comb begin
		ext_page  = `PAGE_BAD_EXT;
		ext_combo = 1'b0;
		if (hi_digit[4]) ext_page[7:4] = hi_digit[3:0];
		if (lo_digit[4]) ext_page[3:0] = lo_digit[3:0];
		if (ioctl_file_ext[15:0] == "ZZ") ext_page = '0;
		if (ioctl_file_ext[15:0] == "Z0") begin
			ext_page  = '0;    // combo image, ends in the high ROM area
			ext_combo = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d <= 1'b0;
			wr_d       <= 1'b0;
			combo      <= 1'b0;
			page       <= '0;
			rom_map    <= '0;
		end else begin
			download_d <= ioctl_download;
			wr_d       <= boot_wr_region;
			if (wr_fall) begin
				if (boot_addr[`BOOT_ADDR_W-1])
					rom_map[boot_addr[21:14]] <= 1'b1;
				if (combo && &boot_addr[13:0]) begin
					combo <= 1'b0;
					page  <= `PAGE_COMBO_END;
				end
			end
			if (ext_start) begin
				page  <= ext_page;
				combo <= ext_combo;
			end
		end
	end

endmodule

// ==== files.f ====
+incdir+design
design/cpc_pkg.sv
design/cpu_bus_if.sv
design/boot_addr_mapper.sv
design/rom_page_tracker.sv
design/mf2_control.sv
design/mf2_shadow_ram.sv
design/cpc_glue_top.sv
verification/tb_cpc_glue.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator and run it; pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
	--top-module tb_cpc_glue -f files.f \
	&& ./obj_dir/Vtb_cpc_glue | tee /dev/stderr | grep -xF "** PASS **" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== verification/tb_cpc_glue.sv ====
// testbench for cpc_glue_top covering downloads, rom map, Multiface paging and shadow RAM
`include "cpc_cfg.svh"

module tb_cpc_glue;
	timeunit 1ns;
	timeprecision 100ps;
	import cpc_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int WAIT_LIMIT = 20;       // cycles per wait

	logic clk_sys = 1'b0;
	logic reset;
	logic ioctl_download, ioctl_wr, model;
	byte_t ioctl_index, ioctl_dout, cpu_dout, mf2_dout, boot_data, expect_byte;
	logic [`IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [23:0] ioctl_file_ext;
	cpu_addr_t cpu_addr;
	logic cpu_m1, cpu_iorq, cpu_rd, cpu_wr, mem_rd, mem_wr, key_nmi;
	mf2_mode_t mf2_mode;
	logic boot_wr, mf2_nmi, mf2_rom_en, mf2_ram_en;
	boot_addr_t boot_addr;
	bank_t boot_bank;
	logic [`ROM_MAP_W-1:0] rom_map;
	logic expect_open;                    // FEE8 should page the Multiface in
	int errors = 0;
	int timeouts = 0;
	wire io_write = cpu_iorq & cpu_wr & ~cpu_rd;

	cpc_glue_top u_dut (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// fixed firmware page for segment 0-3 of either set
	function automatic page_t fw_page(input logic [1:0] seg);
		case (seg)
			2'd0:    return `PAGE_OS;
			2'd1:    return `PAGE_BASIC;
			2'd2:    return `PAGE_AMSDOS;
			default: return `PAGE_MF2;
		endcase
	endfunction

	function automatic logic [4:0] char_nibble(input byte_t c);
		byte_t v;
		v = 8'h00;
		if (c >= "0" && c <= "9") v = c - "0" + 8'h10;
		if (c >= "A" && c <= "F") v = c - "A" + 8'h1A;
		return v[4:0];                    // bit 4 flags a hex digit
	endfunction

	// memory page for an expansion write from the two extension characters
	function automatic page_t ext_target(input logic [15:0] ext, input logic [7:0] seg);
		page_t p;
		logic [4:0] hi;
		logic [4:0] lo;
		hi = char_nibble(ext[15:8]);
		lo = char_nibble(ext[7:0]);
		p = `PAGE_BAD_EXT;
		if (hi[4]) p[7:4] = hi[3:0];
		if (lo[4]) p[3:0] = lo[3:0];
		if (ext == "ZZ" || ext == "Z0") p = 9'h000;
		return {p[8], p[7:0] + seg};
	endfunction

	task automatic report_mismatch(input string what);
		errors++;
		$display("ERR %0t: %s", $time, what);
	endtask

	////////////////////////////////////////
	// checks

	fw_map: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_download && ioctl_index == `IDX_ROM && ioctl_wr && ioctl_addr[24:14] < 8
		|-> boot_wr && boot_addr[22:14] == fw_page(ioctl_addr[15:14])
			&& boot_bank == {1'b0, ioctl_addr[16]} && boot_addr[13:0] == ioctl_addr[13:0])
		else report_mismatch("firmware segment mapped wrong");
	fw_end: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_download && ioctl_index == `IDX_ROM && ioctl_wr && ioctl_addr[24:14] >= 8
		|-> !boot_wr)
		else report_mismatch("write past the firmware image");
	ext_map: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_download && ioctl_index == `IDX_EXT && ioctl_wr
		|-> boot_wr && boot_addr[22:14] == ext_target(ioctl_file_ext[15:0], ioctl_addr[21:14])
			&& boot_bank == {1'b0, model} && boot_addr[13:0] == ioctl_addr[13:0])
		else report_mismatch("expansion page or bank wrong");
	data_through: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> boot_data == ioctl_dout)
		else report_mismatch("boot_data differs from the download byte");
	map_set: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(ioctl_wr) && $past(boot_wr) && boot_addr[22] |=> rom_map[$past(boot_addr[21:14])])
		else report_mismatch("rom_map bit not set");
	map_keep: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(ioctl_wr) && $past(boot_wr) && !boot_addr[22] |=> rom_map == $past(rom_map))
		else report_mismatch("rom_map changed for a low page");
	nmi_arm: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(key_nmi) && mf2_mode == MF2_ENABLED && cpu_addr[15:13] == 3'b000
			&& !mf2_rom_en && !mf2_nmi |=> mf2_nmi)
		else report_mismatch("key did not arm the NMI");
	nmi_blocked: assert property (@(posedge clk_sys) disable iff (reset)
		mf2_mode[1] && !mf2_nmi |=> !mf2_nmi)
		else report_mismatch("NMI rose while disabled");
	nmi_vector: assert property (@(posedge clk_sys) disable iff (reset)
		mf2_nmi && $rose(cpu_m1) && cpu_addr == `MF2_NMI_VEC |=> !mf2_nmi && mf2_rom_en)
		else report_mismatch("vector fetch did not page in");
	port_off: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(io_write) && cpu_addr == 16'hFEEA |=> !mf2_rom_en)
		else report_mismatch("FEEA left the Multiface paged in");
	port_on: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(io_write) && cpu_addr == 16'hFEE8 |=> mf2_rom_en == $past(expect_open))
		else report_mismatch("FEE8 paging wrong");
	shadow_read: assert property (@(posedge clk_sys) disable iff (reset)
		$past(mem_rd, 2) && !$past(mem_rd, 3) |-> mf2_ram_en && mf2_dout == expect_byte)
		else report_mismatch("Multiface RAM read back wrong");
	dout_idle: assert property (@(posedge clk_sys) disable iff (reset)
		!mem_rd |-> mf2_dout == 8'hFF)
		else report_mismatch("mf2_dout not FF without a read");

	////////////////////////////////////////
	// stimulus

	task automatic tick(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic start_download(input byte_t index, input logic [15:0] ext);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= index;
		ioctl_file_ext <= {"R", ext};
		tick(2);                          // page settles after the start
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		tick(1);
	endtask

	task automatic write_byte(input logic [10:0] seg);
		logic [31:0] r;
		r = $urandom;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= {seg, r[13:0]};
		ioctl_dout <= r[21:14];
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		tick(1);
	endtask

	task automatic io_out(input cpu_addr_t addr, input byte_t data);
		@(posedge clk_sys);
		cpu_addr <= addr;
		cpu_dout <= data;
		cpu_iorq <= 1'b1;
		cpu_wr   <= 1'b1;
		@(posedge clk_sys);
		cpu_iorq <= 1'b0;
		cpu_wr   <= 1'b0;
		cpu_addr <= 16'h0100;             // idle in the ROM window
		tick(1);
	endtask

	task automatic fetch(input cpu_addr_t addr);
		@(posedge clk_sys);
		cpu_m1   <= 1'b1;
		cpu_addr <= addr;
		@(posedge clk_sys);
		cpu_m1   <= 1'b0;
		cpu_addr <= 16'h0100;
		tick(1);
	endtask

	task automatic mem_access(input cpu_addr_t addr, input logic write, input byte_t data);
		@(posedge clk_sys);
		cpu_addr <= addr;
		cpu_dout <= data;
		mem_wr   <= write;
		mem_rd   <= ~write;
		tick(4);
		@(posedge clk_sys);
		mem_wr   <= 1'b0;
		mem_rd   <= 1'b0;
		cpu_addr <= 16'h0100;
	endtask

	task automatic press_key();
		@(posedge clk_sys);
		key_nmi <= 1'b1;
		tick(2);
		@(posedge clk_sys);
		key_nmi <= 1'b0;
	endtask

	task automatic wait_nmi(input logic level);
		int n;
		n = 0;
		while (mf2_nmi !== level && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (mf2_nmi !== level) begin
			timeouts++;
			$display("timeout at %0t: mf2_nmi never went to %0b", $time, level);
		end
	endtask

	task automatic enter_nmi();
		press_key();
		wait_nmi(1'b1);
		fetch(`MF2_NMI_VEC);
		wait_nmi(1'b0);
		expect_open <= 1'b1;
	endtask

	initial begin
		byte_t b;
		cpu_addr_t a;
		void'($urandom(32'hd14e));
		reset = 1'b1;
		{ioctl_download, ioctl_wr, model, cpu_m1, cpu_iorq, cpu_rd, cpu_wr} = '0;
		{mem_rd, mem_wr, key_nmi, expect_open} = '0;
		ioctl_index = '0;
		ioctl_dout = '0;
		ioctl_addr = '0;
		ioctl_file_ext = '0;
		cpu_addr = 16'h0100;
		cpu_dout = '0;
		expect_byte = 8'hFF;
		mf2_mode = MF2_ENABLED;
		tick(8);
		reset <= 1'b0;

		start_download(`IDX_ROM, "  ");   // segment 8 is past the image
		for (int seg = 0; seg < 9; seg++)
			write_byte(11'(seg));
		end_download();

		model <= 1'($urandom);
		start_download(`IDX_EXT, "1A");
		write_byte(11'd0);
		end_download();
		start_download(`IDX_EXT, "Q!");
		write_byte(11'd0);
		end_download();
		start_download(`IDX_EXT, "ZZ");
		write_byte(11'd0);
		end_download();

		mf2_mode <= MF2_DISABLED;         // key must not arm the NMI
		press_key();
		tick(3);
		mf2_mode <= MF2_ENABLED;
		enter_nmi();

		io_out(16'hFEEA, 8'h00);
		io_out(16'hFEE8, 8'h00);
		fetch(`MF2_HIDE_ADDR);
		expect_open <= 1'b0;
		io_out(16'hFEE8, 8'h00);

		enter_nmi();
		b = {2'b10, 6'($urandom)};        // screen mode write
		expect_byte <= b;
		io_out(16'h7F00, b);
		mem_access(16'h3FEF, 1'b0, 8'h00);
		b = 8'($urandom);
		a = 16'h2000 | 16'($urandom & 32'h0FFF);
		expect_byte <= b;
		mem_access(a, 1'b1, b);
		mem_access(a, 1'b0, 8'h00);
		tick(4);

		$display("checks failed: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
